/* hdl/cla_pkg.sv */
package cla_pkg;

    // Largest number of groups one lookahead level combines
    localparam int max_groups = 4;

    // Generate and propagate for a bit or for a whole group
    typedef struct packed {
        logic g;
        logic p;
    } pg_t;

endpackage

/* hdl/alu_pkg.sv */
package alu_pkg;

    localparam int data_width_default = 32;

    typedef logic [data_width_default-1:0] data_t;

    typedef enum logic [1:0] {
        op_add = 2'b00,
        op_adc = 2'b01,
        op_sub = 2'b10,
        op_sbb = 2'b11
    } alu_op_e;

    // Carry reads as "no borrow" on subtraction
    typedef struct packed {
        logic carry;
        logic overflow;
        logic zero;
        logic negative;
    } alu_flags_t;

    typedef struct packed {
        alu_op_e op;
        data_t   a;
        data_t   b;
        logic    cin;
    } alu_req_t;

    typedef struct packed {
        data_t      result;
        alu_flags_t flags;
    } alu_rsp_t;

endpackage

/* hdl/cla4_block.sv */
`timescale 1ns/1ps

module cla4_block
    import cla_pkg::*;
(
    input  logic [3:0] a,
    input  logic [3:0] b,
    input  logic       cin,
    output logic [3:0] sum,
    output pg_t        group
);

    logic [3:0] g;
    logic [3:0] p;
    logic [3:0] c;

    // Per-bit terms
    assign g = a & b;
    assign p = a ^ b;

    // Two-level lookahead carries, no ripple between bits
    assign c[0] = cin;
    assign c[1] = g[0] | (p[0] & cin);
    assign c[2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & cin);
    assign c[3] = g[2]
                | (p[2] & g[1])
                | (p[2] & p[1] & g[0])
                | (p[2] & p[1] & p[0] & cin);

    assign sum = p ^ c;

    // Group terms for the next lookahead level
    assign group.g = g[3]
                   | (p[3] & g[2])
                   | (p[3] & p[2] & g[1])
                   | (p[3] & p[2] & p[1] & g[0]);
    assign group.p = &p;

endmodule

/* hdl/carry_lookahead_unit.sv */
`timescale 1ns/1ps

module carry_lookahead_unit
    import cla_pkg::*;
#(
    parameter int n_groups = max_groups
) (
    input  pg_t [n_groups-1:0] gp,
    input  logic               cin,
    output logic [n_groups-1:0] carries,
    output logic               cout,
    output pg_t                group
);

    // Index i holds the carry into group i, index n_groups the carry out
    logic [n_groups:0] carry_all;
    logic [n_groups:0] gen_all;
    logic              group_p;

    always_comb begin
        logic term;
        carry_all = '0;
        gen_all   = '0;
        for (int i = 0; i <= n_groups; i++) begin
            // One product per lower group that generates
            for (int j = 0; j < i; j++) begin
                term = gp[j].g;
                for (int k = j + 1; k < i; k++) begin
                    term = term & gp[k].p;
                end
                gen_all[i] = gen_all[i] | term;
            end
            // Carry-in surviving every lower group
            term = cin;
            for (int k = 0; k < i; k++) begin
                term = term & gp[k].p;
            end
            carry_all[i] = gen_all[i] | term;
        end
    end

    always_comb begin
        group_p = 1'b1;
        for (int k = 0; k < n_groups; k++) begin
            group_p = group_p & gp[k].p;
        end
    end

    assign carries = carry_all[n_groups-1:0];
    assign cout    = carry_all[n_groups];
    assign group.g = gen_all[n_groups];
    assign group.p = group_p;

endmodule

/* hdl/cla_adder.sv */
`timescale 1ns/1ps

module cla_adder
    import cla_pkg::*;
#(
    parameter int width = 32
) (
    input  logic [width-1:0] a,
    input  logic [width-1:0] b,
    input  logic             cin,
    output logic [width-1:0] sum,
    output logic             cout,
    output logic             msb_cin,
    output pg_t              group
);

    if (width == 4) begin : g_leaf

        cla4_block u_block (
            .a     (a),
            .b     (b),
            .cin   (cin),
            .sum   (sum),
            .group (group)
        );

        assign cout = group.g | (group.p & cin);

        // Carry into the top bit, recovered from its sum bit
        assign msb_cin = sum[3] ^ a[3] ^ b[3];

    end else begin : g_tree

        // Four-way split where it divides evenly, else halves
        localparam int n_groups  = (width % 16 == 0) ? max_groups : 2;
        localparam int sub_width = width / n_groups;

        pg_t  [n_groups-1:0] sub_gp;
        logic [n_groups-1:0] sub_cin;
        logic [n_groups-1:0] sub_msb;

        for (genvar i = 0; i < n_groups; i++) begin : g_sub
            cla_adder #(
                .width (sub_width)
            ) u_sub (
                .a       (a[i*sub_width +: sub_width]),
                .b       (b[i*sub_width +: sub_width]),
                .cin     (sub_cin[i]),
                .sum     (sum[i*sub_width +: sub_width]),
                .cout    (),
                .msb_cin (sub_msb[i]),
                .group   (sub_gp[i])
            );
        end

        carry_lookahead_unit #(
            .n_groups (n_groups)
        ) u_clu (
            .gp      (sub_gp),
            .cin     (cin),
            .carries (sub_cin),
            .cout    (cout),
            .group   (group)
        );

        // Only the top sub-adder holds the sign bit
        assign msb_cin = sub_msb[n_groups-1];

    end

endmodule

/* hdl/addsub_unit.sv */
`timescale 1ns/1ps

module addsub_unit
    import alu_pkg::*;
#(
    parameter int data_width = data_width_default
) (
    input  alu_req_t req,
    output alu_rsp_t rsp
);

    logic                  is_sub;
    logic                  carry_in;
    logic [data_width-1:0] b_cond;
    logic [data_width-1:0] sum;
    logic                  cout;
    logic                  msb_cin;

    // Operand conditioning per operation
    always_comb begin
        is_sub   = 1'b0;
        carry_in = 1'b0;
        unique case (req.op)
            op_add: carry_in = 1'b0;
            op_adc: carry_in = req.cin;
            op_sub: begin
                is_sub   = 1'b1;
                carry_in = 1'b1;
            end
            op_sbb: begin
                is_sub   = 1'b1;
                carry_in = req.cin;
            end
        endcase
    end

    assign b_cond = is_sub ? ~req.b : req.b;

    cla_adder #(
        .width (data_width)
    ) u_adder (
        .a       (req.a),
        .b       (b_cond),
        .cin     (carry_in),
        .sum     (sum),
        .cout    (cout),
        .msb_cin (msb_cin),
        .group   ()
    );

    always_comb begin
        rsp.result         = sum;
        rsp.flags.carry    = cout;
        // Signed overflow when carries into and out of the sign bit differ
        rsp.flags.overflow = cout ^ msb_cin;
        rsp.flags.zero     = ~|sum;
        rsp.flags.negative = sum[data_width-1];
    end

endmodule

/* hdl/alu_stage.sv */
`timescale 1ns/1ps

module alu_stage
    import alu_pkg::*;
#(
    parameter int data_width = data_width_default
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  alu_req_t req,
    output logic     out_valid,
    output alu_rsp_t rsp
);

    alu_req_t req_q;
    logic     valid_q;
    alu_rsp_t rsp_d;

    // Input register
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
            req_q   <= '0;
        end else begin
            valid_q <= in_valid;
            if (in_valid) begin
                req_q <= req;
            end
        end
    end

    addsub_unit #(
        .data_width (data_width)
    ) u_addsub (
        .req (req_q),
        .rsp (rsp_d)
    );

    // Output register, one pulse per accepted request
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            rsp       <= '0;
        end else begin
            out_valid <= valid_q;
            if (valid_q) begin
                rsp <= rsp_d;
            end
        end
    end

endmodule

/* testbench/tb_alu_stage.sv */
`timescale 1ns/1ps

module tb_alu_stage
    import alu_pkg::*;
();

    localparam int data_width = 32;
    localparam int max_gap    = 3;

    // One trace line with its request, expected response and gap flag
    typedef struct packed {
        logic     gap;
        alu_req_t req;
        alu_rsp_t rsp;
    } trace_entry_t;

    typedef struct packed {
        alu_rsp_t rsp;
        int       issue_cycle;
    } pending_t;

    logic     clk = 1'b0;
    logic     rst;
    logic     in_valid;
    alu_req_t req;
    logic     out_valid;
    alu_rsp_t rsp;

    trace_entry_t trace_q[$];
    pending_t     expect_q[$];
    int           cycles = 0;
    int           cycle_limit = 0;

    alu_stage #(
        .data_width (data_width)
    ) UUT (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .req       (req),
        .out_valid (out_valid),
        .rsp       (rsp)
    );

    always #50 clk = ~clk;

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_result(input logic [data_width-1:0] got,
                                input logic [data_width-1:0] expected);
        if (got !== expected) begin
            fail_run($sformatf("Mismatch at %0t: result expected %h got %h",
                               $time, expected, got));
        end
    endtask

    task automatic check_flags(input alu_flags_t got, input alu_flags_t expected);
        if (got !== expected) begin
            fail_run($sformatf("Mismatch at %0t: flags (c v z n) expected %b got %b",
                               $time, expected, got));
        end
    endtask

    task automatic check_latency(input int got, input int expected);
        if (got !== expected) begin
            fail_run($sformatf("Mismatch at %0t: response in cycle %0d, expected cycle %0d",
                               $time, got, expected));
        end
    endtask

    task automatic load_trace();
        int                    fd;
        int                    count;
        string                 line;
        logic [1:0]            op;
        logic [data_width-1:0] a;
        logic [data_width-1:0] b;
        logic                  cin;
        logic [data_width-1:0] result;
        logic [3:0]            flags;
        logic                  gap;
        trace_entry_t          entry;
        fd = $fopen("testbench/alu_trace.txt", "r");
        if (fd == 0) begin
            fail_run("Cannot open trace file testbench/alu_trace.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // Skip blank lines and comments
            if (line.len() < 2 || line.substr(0, 0) == "#") begin
                continue;
            end
            count = $sscanf(line, "%h %h %h %h %h %h %h",
                            op, a, b, cin, result, flags, gap);
            if (count != 7) begin
                fail_run($sformatf("Malformed line in trace file: %s", line));
            end
            entry.gap          = gap;
            entry.req.op       = alu_op_e'(op);
            entry.req.a        = a;
            entry.req.b        = b;
            entry.req.cin      = cin;
            entry.rsp.result   = result;
            entry.rsp.flags    = alu_flags_t'(flags);
            trace_q.push_back(entry);
        end
        $fclose(fd);
        if (trace_q.size() == 0) begin
            fail_run("Trace file holds no requests");
        end
    endtask

    // Cycle counter and watchdog
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            fail_run($sformatf("Timeout after %0d cycles without finishing", cycles));
        end
    end

    // Scoreboard sampled mid-cycle where outputs are settled
    always @(negedge clk) begin
        pending_t head;
        if (out_valid !== 1'b0) begin
            if (expect_q.size() == 0) begin
                fail_run($sformatf("out_valid high at %0t with no request pending", $time));
            end else begin
                head = expect_q.pop_front();
                check_result(rsp.result, head.rsp.result);
                check_flags(rsp.flags, head.rsp.flags);
                // Input register on the next edge, output register on the one after
                check_latency(cycles, head.issue_cycle + 2);
            end
        end
    end

    initial begin
        int       gap_cycles;
        pending_t pending;
        rst      = 1'b1;
        in_valid = 1'b0;
        req      = '0;
        void'($urandom(43123));
        load_trace();
        cycle_limit = trace_q.size() * 8 + 100;

        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        foreach (trace_q[i]) begin
            if (trace_q[i].gap) begin
                gap_cycles = $urandom % (max_gap + 1);
                repeat (gap_cycles) begin
                    @(posedge clk);
                    #1;
                    in_valid = 1'b0;
                end
            end
            @(posedge clk);
            #1;
            in_valid            = 1'b1;
            req                 = trace_q[i].req;
            pending.rsp         = trace_q[i].rsp;
            pending.issue_cycle = cycles;
            expect_q.push_back(pending);
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        req      = '0;

        // A few cycles drain the two-stage pipeline
        repeat (4) @(posedge clk);
        if (expect_q.size() != 0) begin
            fail_run($sformatf("%0d responses never arrived", expect_q.size()));
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

/* testbench/alu_trace.txt */
# Columns: op a b cin result flags gap (all hex)
# op 0 add, 1 adc, 2 sub, 3 sbb; flags bits carry overflow zero negative; gap 1 allows idle cycles
# Back-to-back section, carry chains across group boundaries
0 00000000 00000000 0 00000000 2 0
0 FFFFFFFF 00000001 0 00000000 A 0
0 0000000F 00000001 0 00000010 0 0
0 0000FFFF 00000001 0 00010000 0 0
0 000FFFFF 00000001 0 00100000 0 0
0 00FFFFFF 00000001 0 01000000 0 0
0 7FFFFFFF 00000001 0 80000000 5 0
0 80000000 80000000 0 00000000 E 0
0 12345678 11111111 0 23456789 0 0
0 FFFFFFFF FFFFFFFF 0 FFFFFFFE 9 0
0 0F0F0F0F F0F0F0F1 0 00000000 A 0
0 8000FFFF 00010001 0 80020000 1 0
# Add with carry, cin 0 and 1
1 00000005 00000003 0 00000008 0 0
1 00000005 00000003 1 00000009 0 0
1 FFFFFFFF 00000000 1 00000000 A 0
1 FFFFFFFF 00000000 0 FFFFFFFF 1 0
1 7FFFFFFF 00000000 1 80000000 5 0
1 FFFFFFFF FFFFFFFF 1 FFFFFFFF 9 0
# Subtraction, carry means no borrow
2 0000000A 00000003 0 00000007 8 0
2 00000003 0000000A 0 FFFFFFF9 1 0
2 12345678 12345678 0 00000000 A 0
2 00000000 00000001 0 FFFFFFFF 1 0
2 80000000 00000001 0 7FFFFFFF C 0
2 7FFFFFFF FFFFFFFF 0 80000000 5 0
2 FFFFFFFF FFFFFFFF 0 00000000 A 0
2 00000000 00000000 0 00000000 A 0
2 80000000 80000000 0 00000000 A 0
# Random gap section, subtract with borrow first
3 0000000A 00000003 1 00000007 8 1
3 0000000A 00000003 0 00000006 8 1
3 00000000 00000000 0 FFFFFFFF 1 1
3 00000000 00000000 1 00000000 A 1
3 80000000 00000000 0 7FFFFFFF C 1
3 00000005 00000005 0 FFFFFFFF 1 1
3 00000005 00000005 1 00000000 A 1
# Mixed operations
0 00000000 80000000 0 80000000 1 1
2 00000001 80000000 0 80000001 5 1
2 FFFFFFFF 00000001 0 FFFFFFFE 9 1
1 0000FFFF 0000FFFF 1 0001FFFF 0 1
0 DEADBEEF 21524111 0 00000000 A 1
2 00010000 00000001 0 0000FFFF 8 1

/* vlog.f */
hdl/cla_pkg.sv
hdl/alu_pkg.sv
hdl/cla4_block.sv
hdl/carry_lookahead_unit.sv
hdl/cla_adder.sv
hdl/addsub_unit.sv
hdl/alu_stage.sv
testbench/tb_alu_stage.sv
